// File: project.f
+incdir+common
+incdir+sim
common/bpu_pkg.sv
common/decode_pkg.sv
bpu/bpu_btb.sv
bpu/bpu_bht.sv
bpu/bpu_ras.sv
rtl/branch_feedback.sv
rtl/branch_unit.sv
sim/branch_unit_tb.sv

// File: Makefile
# Verilator flow for the branch prediction unit

TOP := branch_unit_tb

.PHONY: lint sim clean

# RTL only, all warnings on
lint:
	verilator --lint-only -Wall --timing -f project.f --top-module branch_unit

# Build and run, pass only when the testbench prints its pass line
sim:
	verilator --binary --timing --assert -f project.f --top-module $(TOP) -o $(TOP)
	@out="$$(./obj_dir/$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "=== PASS ==="

clean:
	rm -rf obj_dir

// File: sim/branch_unit_tests.svh
// Directed tests for fetch prediction, branch resolution, BTB, BHT and RAS behavior

// ----------------------------------------
// Drivers
// ----------------------------------------

task automatic check_predict(string name, bpu_pkg::addr_t pc, bpu_pkg::addr_t expected);
	@(negedge clk);
	fetch_pc_i = pc;
	#1;
	check_value(name, "pred_npc_o", expected, pred_npc_o);
endtask

// Tables update on the edge after the resolve strobe
task automatic resolve_branch(string name, bpu_pkg::addr_t pc, bpu_pkg::addr_t rj,
		bpu_pkg::addr_t rd, decode_pkg::offs_t offs, decode_pkg::branch_type_e bt,
		decode_pkg::cmp_type_e ct, logic link, bpu_pkg::addr_t pred);
	bpu_pkg::addr_t exp_npc;
	logic           exp_taken;
	exp_taken = model_taken(bt, ct, rj, rd);
	exp_npc   = model_next_pc(bt, ct, pc, rj, rd, offs);
	@(negedge clk);
	resolve_valid_i = 1'b1;
	pc_i            = pc;
	rj_i            = rj;
	rd_i            = rd;
	offs_i          = offs;
	branch_type_i   = bt;
	cmp_type_i      = ct;
	branch_link_i   = link;
	pred_npc_i      = pred;
	#1;
	check_value(name, "taken_o", 32'(exp_taken), 32'(taken_o));
	check_value(name, "next_pc_o", exp_npc, next_pc_o);
	check_value(name, "flush_o", 32'(pred != exp_npc), 32'(flush_o));
	@(negedge clk);
	resolve_valid_i = 1'b0;
endtask

// ----------------------------------------
// Tests
// ----------------------------------------

task automatic test_reset_predict();
	bpu_pkg::addr_t pc;
	for (int i = 0; i < 32; i++) begin
		pc = $urandom() & 32'hffff_fffc;
		check_predict("reset_predict", pc, pc + 32'd4);
	end
endtask

task automatic test_cond_resolve();
	bpu_pkg::addr_t    pc;
	bpu_pkg::addr_t    a;
	bpu_pkg::addr_t    b;
	decode_pkg::offs_t offs;
	for (int c = 0; c < 8; c++) begin
		for (int k = 0; k < 10; k++) begin
			pc   = $urandom() & 32'hffff_fffc;
			a    = $urandom();
			b    = $urandom();
			offs = decode_pkg::offs_t'($urandom());
			// Equal operands, then operands of opposite sign both ways
			case (k)
				0: b = a;
				1: begin
					a = a | 32'h8000_0000;
					b = b & 32'h7fff_ffff;
				end
				2: begin
					a = a & 32'h7fff_ffff;
					b = b | 32'h8000_0000;
				end
				default: ;
			endcase
			resolve_branch("cond_resolve", pc, a, b, offs, decode_pkg::BRANCH_CONDITION,
				decode_pkg::cmp_type_e'(c[2:0]), 1'b0, pc + 32'd4);
		end
	end
endtask

task automatic test_btb_learn();
	decode_pkg::offs_t offs_b;
	offs_b = {16'h0010, 5'd5, 5'd0};
	apply_reset();
	// Backward immediate branch
	resolve_branch("btb_learn", 32'h0000_1000, '0, '0, 26'h3ff_ff00,
		decode_pkg::BRANCH_IMMEDIATE, decode_pkg::CMP_EQL, 1'b0, 32'h0000_1004);
	check_predict("btb_learn", 32'h0000_1000, model_target(decode_pkg::BRANCH_IMMEDIATE,
		32'h0000_1000, '0, 26'h3ff_ff00));
	// Register jump through r5
	resolve_branch("btb_learn", 32'h0000_2040, 32'h0000_8000, '0, offs_b,
		decode_pkg::BRANCH_INDIRECT, decode_pkg::CMP_EQL, 1'b0, 32'h0000_2044);
	check_predict("btb_learn", 32'h0000_2040, model_target(decode_pkg::BRANCH_INDIRECT,
		32'h0000_2040, 32'h0000_8000, offs_b));
endtask

task automatic test_bht_train();
	bpu_pkg::addr_t    pc;
	decode_pkg::offs_t offs;
	pc   = 32'h0000_3080;
	offs = {16'h0020, 5'd4, 5'd6};
	apply_reset();
	repeat (2) begin
		resolve_branch("bht_train", pc, 32'd7, 32'd7, offs, decode_pkg::BRANCH_CONDITION,
			decode_pkg::CMP_EQL, 1'b0, pc + 32'd4);
	end
	check_predict("bht_train", pc, pc + 32'h80);
	// One not-taken leaves the counter on the taken side
	resolve_branch("bht_train", pc, 32'd7, 32'd9, offs, decode_pkg::BRANCH_CONDITION,
		decode_pkg::CMP_EQL, 1'b0, pc + 32'h80);
	check_predict("bht_train", pc, pc + 32'h80);
	resolve_branch("bht_train", pc, 32'd7, 32'd9, offs, decode_pkg::BRANCH_CONDITION,
		decode_pkg::CMP_EQL, 1'b0, pc + 32'h80);
	check_predict("bht_train", pc, pc + 32'd4);
endtask

task automatic test_call_return();
	decode_pkg::offs_t offs_ret;
	offs_ret = {16'h0000, 5'd1, 5'd0};
	apply_reset();
	resolve_branch("call_return", 32'h0000_4000, '0, '0, 26'h400,
		decode_pkg::BRANCH_IMMEDIATE, decode_pkg::CMP_EQL, 1'b1, 32'h0000_4004);
	check_predict("call_return", 32'h0000_4000, 32'h0000_5000);
	// Return to another address pops the only entry
	resolve_branch("call_return", 32'h0000_5010, 32'h0000_6000, '0, offs_ret,
		decode_pkg::BRANCH_INDIRECT, decode_pkg::CMP_EQL, 1'b0, 32'h0000_4004);
	// Empty stack falls back to the BTB target
	check_predict("call_return", 32'h0000_5010, 32'h0000_6000);
	// Second call site makes the return follow the stack
	resolve_branch("call_return", 32'h0000_4800, '0, '0, 26'h200,
		decode_pkg::BRANCH_IMMEDIATE, decode_pkg::CMP_EQL, 1'b1, 32'h0000_4804);
	check_predict("call_return", 32'h0000_5010, 32'h0000_4804);
	resolve_branch("call_return", 32'h0000_5010, 32'h0000_4804, '0, offs_ret,
		decode_pkg::BRANCH_INDIRECT, decode_pkg::CMP_EQL, 1'b0, 32'h0000_4804);
	check_predict("call_return", 32'h0000_5010, 32'h0000_4804);
endtask

task automatic test_correct_predict();
	bpu_pkg::addr_t    pc;
	bpu_pkg::addr_t    a;
	bpu_pkg::addr_t    b;
	decode_pkg::offs_t offs;
	decode_pkg::cmp_type_e ct;
	for (int i = 0; i < 12; i++) begin
		pc   = $urandom() & 32'hffff_fffc;
		a    = $urandom();
		b    = (i % 3 == 0) ? a : $urandom();
		offs = decode_pkg::offs_t'($urandom());
		ct   = decode_pkg::cmp_type_e'(3'($urandom()));
		resolve_branch("correct_predict", pc, a, b, offs, decode_pkg::BRANCH_CONDITION, ct,
			1'b0, model_next_pc(decode_pkg::BRANCH_CONDITION, ct, pc, a, b, offs));
	end
	// Outputs stay low without a strobe
	@(negedge clk);
	resolve_valid_i = 1'b0;
	pc_i            = $urandom() & 32'hffff_fffc;
	offs_i          = decode_pkg::offs_t'($urandom());
	branch_type_i   = decode_pkg::BRANCH_IMMEDIATE;
	pred_npc_i      = '0;
	#1;
	check_value("correct_predict", "idle taken_o", 32'd0, 32'(taken_o));
	check_value("correct_predict", "idle next_pc_o", 32'd0, next_pc_o);
	check_value("correct_predict", "idle flush_o", 32'd0, 32'(flush_o));
endtask

// File: sim/branch_unit_tb.sv
// Testbench top: clock, reset, DUT instance, reference model, checker, timeout, test sequence
`timescale 1ns/1ns

module branch_unit_tb;

	// Tests take roughly 300 cycles
	localparam int TIMEOUT_CYCLES = 2000;

	logic                     clk;
	logic                     reset_i;
	bpu_pkg::addr_t           fetch_pc_i;
	bpu_pkg::addr_t           pred_npc_o;
	logic                     resolve_valid_i;
	bpu_pkg::addr_t           pc_i;
	bpu_pkg::addr_t           rj_i;
	bpu_pkg::addr_t           rd_i;
	decode_pkg::offs_t        offs_i;
	decode_pkg::branch_type_e branch_type_i;
	decode_pkg::cmp_type_e    cmp_type_i;
	logic                     branch_link_i;
	bpu_pkg::addr_t           pred_npc_i;
	logic                     flush_o;
	bpu_pkg::addr_t           next_pc_o;
	logic                     taken_o;
	int                       cycle_count;

	branch_unit i_branch_unit (.*);

	initial begin
		clk = 1'b0;
		forever #2 clk = ~clk;
	end

	// ----------------------------------------
	// Reference model
	// ----------------------------------------

	function automatic logic model_taken(decode_pkg::branch_type_e bt,
			decode_pkg::cmp_type_e ct, bpu_pkg::addr_t a, bpu_pkg::addr_t b);
		int sa;
		int sb;
		sa = a;
		sb = b;
		if (bt == decode_pkg::BRANCH_INVALID) return 1'b0;
		if (bt != decode_pkg::BRANCH_CONDITION) return 1'b1;
		case (ct)
			decode_pkg::CMP_EQL: return a == b;
			decode_pkg::CMP_NEQ: return a != b;
			decode_pkg::CMP_LSS: return sa < sb;
			decode_pkg::CMP_GER: return sa > sb;
			decode_pkg::CMP_LEQ: return sa <= sb;
			decode_pkg::CMP_GEQ: return sa >= sb;
			decode_pkg::CMP_LTU: return a < b;
			default:             return a >= b;
		endcase
	endfunction

	function automatic bpu_pkg::addr_t model_target(decode_pkg::branch_type_e bt,
			bpu_pkg::addr_t pc, bpu_pkg::addr_t rj, decode_pkg::offs_t offs);
		int off16;
		int off26;
		// Offsets count instruction words
		off16 = int'($signed(offs[25:10])) * 4;
		off26 = int'($signed(offs)) * 4;
		case (bt)
			decode_pkg::BRANCH_IMMEDIATE: return pc + off26;
			decode_pkg::BRANCH_INDIRECT:  return rj + off16;
			decode_pkg::BRANCH_CONDITION: return pc + off16;
			default:                      return pc + 32'd4;
		endcase
	endfunction

	function automatic bpu_pkg::addr_t model_next_pc(decode_pkg::branch_type_e bt,
			decode_pkg::cmp_type_e ct, bpu_pkg::addr_t pc, bpu_pkg::addr_t rj,
			bpu_pkg::addr_t rd, decode_pkg::offs_t offs);
		if (model_taken(bt, ct, rj, rd)) return model_target(bt, pc, rj, offs);
		return pc + 32'd4;
	endfunction

	// ----------------------------------------
	// Checker and reset
	// ----------------------------------------

	task automatic check_value(string test_name, string what, logic [31:0] expected,
			logic [31:0] actual);
		assert (actual === expected) else begin
			$display("[ERROR] %s: %s expected %h, actual %h", test_name, what, expected, actual);
			$display("=== FAIL ===");
			$fatal(1, "Mismatch on %s", what);
		end
	endtask

	task automatic apply_reset();
		@(negedge clk);
		reset_i = 1'b1;
		repeat (5) @(negedge clk);
		reset_i = 1'b0;
	endtask

	`include "branch_unit_tests.svh"

	// Hung run guard
	initial begin
		cycle_count = 0;
		while (cycle_count < TIMEOUT_CYCLES) begin
			@(posedge clk);
			cycle_count++;
		end
		$display("Timeout: the tests did not finish within %0d cycles", TIMEOUT_CYCLES);
		$display("=== FAIL ===");
		$fatal(1, "Timeout");
	end

	initial begin
		void'($urandom(32'ha1814edc));
		reset_i         = 1'b1;
		fetch_pc_i      = '0;
		resolve_valid_i = 1'b0;
		pc_i            = '0;
		rj_i            = '0;
		rd_i            = '0;
		offs_i          = '0;
		branch_type_i   = decode_pkg::BRANCH_INVALID;
		cmp_type_i      = decode_pkg::CMP_EQL;
		branch_link_i   = 1'b0;
		pred_npc_i      = '0;
		apply_reset();
		test_reset_predict();
		test_cond_resolve();
		test_btb_learn();
		test_bht_train();
		test_call_return();
		test_correct_predict();
		$display("=== PASS ===");
		$finish;
	end

endmodule : branch_unit_tb

// File: rtl/branch_unit.sv
// Branch prediction unit top: BTB, BHT, RAS, resolve logic and next-PC select
`timescale 1ns/1ns

module branch_unit (
	input  logic                     clk,
	input  logic                     reset_i,

	// Fetch side
	input  bpu_pkg::addr_t           fetch_pc_i,
	output bpu_pkg::addr_t           pred_npc_o,

	// Resolve side
	input  logic                     resolve_valid_i,
	input  bpu_pkg::addr_t           pc_i,
	input  bpu_pkg::addr_t           rj_i,
	input  bpu_pkg::addr_t           rd_i,
	input  decode_pkg::offs_t        offs_i,
	input  decode_pkg::branch_type_e branch_type_i,
	input  decode_pkg::cmp_type_e    cmp_type_i,
	input  logic                     branch_link_i,
	input  bpu_pkg::addr_t           pred_npc_i,
	output logic                     flush_o,
	output bpu_pkg::addr_t           next_pc_o,
	output logic                     taken_o
);

	logic               btb_hit;
	bpu_pkg::waddr_t    btb_target;
	bpu_pkg::br_class_e btb_class;
	logic               bht_taken;
	bpu_pkg::waddr_t    ras_top;
	logic               ras_empty;

	bpu_pkg::br_class_e res_class;
	logic               btb_we;
	logic               bht_we;
	logic               ras_push;
	logic               ras_pop;
	bpu_pkg::waddr_t    res_ret_addr;
	bpu_pkg::addr_t     fetch_seq;

	assign fetch_seq    = fetch_pc_i + 32'd4;
	assign res_ret_addr = pc_i[31:2] + 30'd1;

	// ----------------------------------------
	// Next-PC select
	// ----------------------------------------

	always_comb begin
		pred_npc_o = fetch_seq;
		if (btb_hit) begin
			case (btb_class)
				bpu_pkg::BR_RETURN:      pred_npc_o = {ras_empty ? btb_target : ras_top, 2'b00};
				bpu_pkg::BR_PC_RELATIVE: pred_npc_o = bht_taken ? {btb_target, 2'b00} : fetch_seq;
				default:                 pred_npc_o = {btb_target, 2'b00};
			endcase
		end
	end

	// ----------------------------------------
	// Tables and resolve
	// ----------------------------------------

	bpu_btb i_bpu_btb (
		.clk         (clk),
		.reset_i     (reset_i),
		.rd_pc_i     (fetch_pc_i[31:2]),
		.hit_o       (btb_hit),
		.rd_target_o (btb_target),
		.rd_class_o  (btb_class),
		.wr_en_i     (btb_we),
		.wr_pc_i     (pc_i[31:2]),
		.wr_target_i (next_pc_o[31:2]),
		.wr_class_i  (res_class)
	);

	bpu_bht i_bpu_bht (
		.clk        (clk),
		.reset_i    (reset_i),
		.rd_pc_i    (fetch_pc_i[31:2]),
		.taken_o    (bht_taken),
		.wr_en_i    (bht_we),
		.wr_pc_i    (pc_i[31:2]),
		.wr_taken_i (taken_o)
	);

	bpu_ras i_bpu_ras (
		.clk         (clk),
		.reset_i     (reset_i),
		.push_i      (ras_push),
		.push_addr_i (res_ret_addr),
		.pop_i       (ras_pop),
		.top_o       (ras_top),
		.empty_o     (ras_empty)
	);

	branch_feedback i_branch_feedback (
		.resolve_valid_i (resolve_valid_i),
		.pc_i            (pc_i),
		.rj_i            (rj_i),
		.rd_i            (rd_i),
		.offs_i          (offs_i),
		.branch_type_i   (branch_type_i),
		.cmp_type_i      (cmp_type_i),
		.branch_link_i   (branch_link_i),
		.pred_npc_i      (pred_npc_i),
		.taken_o         (taken_o),
		.next_pc_o       (next_pc_o),
		.flush_o         (flush_o),
		.br_class_o      (res_class),
		.btb_we_o        (btb_we),
		.bht_we_o        (bht_we),
		.ras_push_o      (ras_push),
		.ras_pop_o       (ras_pop)
	);

endmodule : branch_unit

// File: rtl/branch_feedback.sv
// Branch resolution, misprediction detect and table-update decode
`timescale 1ns/1ns

module branch_feedback (
	input  logic                     resolve_valid_i,
	input  bpu_pkg::addr_t           pc_i,
	input  bpu_pkg::addr_t           rj_i,
	input  bpu_pkg::addr_t           rd_i,
	input  decode_pkg::offs_t        offs_i,
	input  decode_pkg::branch_type_e branch_type_i,
	input  decode_pkg::cmp_type_e    cmp_type_i,
	input  logic                     branch_link_i,
	input  bpu_pkg::addr_t           pred_npc_i,
	output logic                     taken_o,
	output bpu_pkg::addr_t           next_pc_o,
	output logic                     flush_o,
	output bpu_pkg::br_class_e       br_class_o,
	output logic                     btb_we_o,
	output logic                     bht_we_o,
	output logic                     ras_push_o,
	output logic                     ras_pop_o
);

	decode_pkg::reg_idx_t rj_idx;
	decode_pkg::reg_idx_t rd_idx;
	bpu_pkg::addr_t       offs26_ext;
	bpu_pkg::addr_t       offs16_ext;
	bpu_pkg::addr_t       pc_plus4;
	bpu_pkg::addr_t       target;
	bpu_pkg::addr_t       resolved_pc;
	logic                 is_branch;
	logic                 is_indirect;
	logic                 is_cond;
	logic                 cond_hold;
	logic                 taken;

	// Register indices live in the low offset bits
	assign rj_idx = offs_i[9:5];
	assign rd_idx = offs_i[4:0];

	// Sign extended and scaled to bytes
	assign offs26_ext = {{4{offs_i[25]}}, offs_i, 2'b00};
	assign offs16_ext = {{14{offs_i[25]}}, offs_i[25:10], 2'b00};
	assign pc_plus4   = pc_i + 32'd4;

	assign is_branch   = (branch_type_i != decode_pkg::BRANCH_INVALID);
	assign is_indirect = (branch_type_i == decode_pkg::BRANCH_INDIRECT);
	assign is_cond     = (branch_type_i == decode_pkg::BRANCH_CONDITION);

	// ----------------------------------------
	// Target and direction
	// ----------------------------------------

	always_comb begin
		case (branch_type_i)
			decode_pkg::BRANCH_IMMEDIATE: target = pc_i + offs26_ext;
			decode_pkg::BRANCH_INDIRECT:  target = rj_i + offs16_ext;
			decode_pkg::BRANCH_CONDITION: target = pc_i + offs16_ext;
			default:                      target = pc_plus4;
		endcase
	end

	always_comb begin
		case (cmp_type_i)
			decode_pkg::CMP_EQL: cond_hold = (rj_i == rd_i);
			decode_pkg::CMP_NEQ: cond_hold = (rj_i != rd_i);
			decode_pkg::CMP_LSS: cond_hold = ($signed(rj_i) <  $signed(rd_i));
			decode_pkg::CMP_GER: cond_hold = ($signed(rj_i) >  $signed(rd_i));
			decode_pkg::CMP_LEQ: cond_hold = ($signed(rj_i) <= $signed(rd_i));
			decode_pkg::CMP_GEQ: cond_hold = ($signed(rj_i) >= $signed(rd_i));
			decode_pkg::CMP_LTU: cond_hold = (rj_i <  rd_i);
			decode_pkg::CMP_GEU: cond_hold = (rj_i >= rd_i);
			default:             cond_hold = 1'b0;
		endcase
	end

	// Unconditional kinds are always taken
	assign taken       = is_cond ? cond_hold : is_branch;
	assign resolved_pc = taken ? target : pc_plus4;

	// ----------------------------------------
	// Branch class for the BTB and RAS
	// ----------------------------------------

	always_comb begin
		if (is_branch && ((is_indirect && rd_idx == decode_pkg::REG_RA) || branch_link_i)) begin
			br_class_o = bpu_pkg::BR_CALL;
		end else if (is_indirect && rj_idx == decode_pkg::REG_RA && offs_i[25:10] == '0) begin
			br_class_o = bpu_pkg::BR_RETURN;
		end else if (branch_type_i == decode_pkg::BRANCH_IMMEDIATE || is_indirect) begin
			br_class_o = bpu_pkg::BR_ABSOLUTE;
		end else begin
			br_class_o = bpu_pkg::BR_PC_RELATIVE;
		end
	end

	// Outputs qualified by the resolve strobe
	assign taken_o    = resolve_valid_i && taken;
	assign next_pc_o  = resolve_valid_i ? resolved_pc : '0;
	assign flush_o    = resolve_valid_i && (pred_npc_i != resolved_pc);

	// Table strobes
	assign btb_we_o   = taken_o;
	assign bht_we_o   = resolve_valid_i && is_cond;
	assign ras_push_o = resolve_valid_i && (br_class_o == bpu_pkg::BR_CALL);
	assign ras_pop_o  = resolve_valid_i && (br_class_o == bpu_pkg::BR_RETURN);

endmodule : branch_feedback

// File: bpu/bpu_ras.sv
// Circular return address stack with push, pop, top and empty flag
`timescale 1ns/1ns

`include "bpu_params.svh"

module bpu_ras (
	input  logic            clk,
	input  logic            reset_i,
	input  logic            push_i,
	input  bpu_pkg::waddr_t push_addr_i,
	input  logic            pop_i,
	output bpu_pkg::waddr_t top_o,
	output logic            empty_o
);

	bpu_pkg::waddr_t       stack [`RAS_DEPTH];

	// Points at the next free slot
	logic [`RAS_PTR_W-1:0] wr_ptr;
	logic [`RAS_PTR_W-1:0] top_ptr;

	// Occupancy, 0 to RAS_DEPTH
	logic [`RAS_PTR_W:0]   count;

	assign top_ptr = wr_ptr - 1'b1;
	assign top_o   = stack[top_ptr];
	assign empty_o = (count == '0);

	// ----------------------------------------
	// Pointer and occupancy
	// ----------------------------------------

	always_ff @(posedge clk) begin
		if (reset_i) begin
			wr_ptr <= '0;
			count  <= '0;
		end else if (push_i) begin
			wr_ptr <= wr_ptr + 1'b1;
			// Full stack drops the oldest entry
			if (count != `RAS_DEPTH) begin
				count <= count + 1'b1;
			end
		end else if (pop_i && !empty_o) begin
			wr_ptr <= top_ptr;
			count  <= count - 1'b1;
		end
	end

	// ----------------------------------------
	// Entries
	// ----------------------------------------

	always_ff @(posedge clk) begin
		if (push_i) begin
			stack[wr_ptr] <= push_addr_i;
		end
	end

endmodule : bpu_ras

// File: bpu/bpu_bht.sv
// Table of 2-bit saturating direction counters
`timescale 1ns/1ns

`include "bpu_params.svh"

module bpu_bht (
	input  logic            clk,
	input  logic            reset_i,
	input  bpu_pkg::waddr_t rd_pc_i,
	output logic            taken_o,
	input  logic            wr_en_i,
	input  bpu_pkg::waddr_t wr_pc_i,
	input  logic            wr_taken_i
);

	bpu_pkg::ctr_t         counters [`BHT_DEPTH];
	logic [`BHT_IDX_W-1:0] rd_idx;
	logic [`BHT_IDX_W-1:0] wr_idx;
	bpu_pkg::ctr_t         wr_ctr;

	// Hash of two PC slices spreads nearby branches
	assign rd_idx = rd_pc_i[`BHT_IDX_W-1:0] ^ rd_pc_i[2*`BHT_IDX_W-1:`BHT_IDX_W];
	assign wr_idx = wr_pc_i[`BHT_IDX_W-1:0] ^ wr_pc_i[2*`BHT_IDX_W-1:`BHT_IDX_W];

	assign taken_o = counters[rd_idx][1];
	assign wr_ctr  = counters[wr_idx];

	always_ff @(posedge clk) begin
		if (reset_i) begin
			for (int i = 0; i < `BHT_DEPTH; i++) begin
				counters[i] <= bpu_pkg::CTR_WEAK_NT;
			end
		end else if (wr_en_i) begin
			// Saturate at both ends
			if (wr_taken_i && wr_ctr != bpu_pkg::CTR_STRONG_T) begin
				counters[wr_idx] <= wr_ctr + 2'd1;
			end else if (!wr_taken_i && wr_ctr != bpu_pkg::CTR_STRONG_NT) begin
				counters[wr_idx] <= wr_ctr - 2'd1;
			end
		end
	end

endmodule : bpu_bht

// File: bpu/bpu_btb.sv
// Direct-mapped branch target buffer with tag, target and branch class per entry
`timescale 1ns/1ns

`include "bpu_params.svh"

module bpu_btb (
	input  logic               clk,
	input  logic               reset_i,

	// Lookup port
	input  bpu_pkg::waddr_t    rd_pc_i,
	output logic               hit_o,
	output bpu_pkg::waddr_t    rd_target_o,
	output bpu_pkg::br_class_e rd_class_o,

	// Update port
	input  logic               wr_en_i,
	input  bpu_pkg::waddr_t    wr_pc_i,
	input  bpu_pkg::waddr_t    wr_target_i,
	input  bpu_pkg::br_class_e wr_class_i
);

	logic [`BTB_DEPTH-1:0] entry_valid;
	logic [`BTB_TAG_W-1:0] entry_tag [`BTB_DEPTH];
	bpu_pkg::waddr_t       entry_target [`BTB_DEPTH];
	bpu_pkg::br_class_e    entry_class [`BTB_DEPTH];

	logic [`BTB_IDX_W-1:0] rd_idx;
	logic [`BTB_TAG_W-1:0] rd_tag;
	logic [`BTB_IDX_W-1:0] wr_idx;
	logic [`BTB_TAG_W-1:0] wr_tag;

	// Split word address into index and tag
	assign rd_idx = rd_pc_i[`BTB_IDX_W-1:0];
	assign rd_tag = rd_pc_i[29:`BTB_IDX_W];
	assign wr_idx = wr_pc_i[`BTB_IDX_W-1:0];
	assign wr_tag = wr_pc_i[29:`BTB_IDX_W];

	// ----------------------------------------
	// Combinational lookup
	// ----------------------------------------

	assign hit_o       = entry_valid[rd_idx] && (entry_tag[rd_idx] == rd_tag);
	assign rd_target_o = entry_target[rd_idx];
	assign rd_class_o  = entry_class[rd_idx];

	// ----------------------------------------
	// Update on the edge
	// ----------------------------------------

	// Valid bits, cleared on reset
	always_ff @(posedge clk) begin
		if (reset_i) begin
			entry_valid <= '0;
		end else if (wr_en_i) begin
			entry_valid[wr_idx] <= 1'b1;
		end
	end

	// Entry payload
	always_ff @(posedge clk) begin
		if (wr_en_i) begin
			entry_tag[wr_idx]    <= wr_tag;
			entry_target[wr_idx] <= wr_target_i;
			entry_class[wr_idx]  <= wr_class_i;
		end
	end

endmodule : bpu_btb

// File: common/decode_pkg.sv
// Decoder-side types: branch type, compare type, offset field, register index
package decode_pkg;

	// Branch kind from the decoder
	typedef enum logic [1:0] {
		BRANCH_INVALID   = 2'd0,
		BRANCH_IMMEDIATE = 2'd1,
		BRANCH_INDIRECT  = 2'd2,
		BRANCH_CONDITION = 2'd3
	} branch_type_e;

	// Compare for conditional branches
	// LSS..GEQ are signed, LTU and GEU unsigned
	typedef enum logic [2:0] {
		CMP_EQL = 3'd0,
		CMP_NEQ = 3'd1,
		CMP_LSS = 3'd2,
		CMP_GER = 3'd3,
		CMP_LEQ = 3'd4,
		CMP_GEQ = 3'd5,
		CMP_LTU = 3'd6,
		CMP_GEU = 3'd7
	} cmp_type_e;

	// Instruction bits [25:0]
	// rd index sits in [4:0], rj index in [9:5], offs16 in [25:10]
	typedef logic [25:0] offs_t;

	// Architectural register index
	typedef logic [4:0] reg_idx_t;

	// Link register r1
	localparam reg_idx_t REG_RA = 5'd1;

endpackage : decode_pkg

// File: common/bpu_pkg.sv
// Predictor types: byte and word addresses, direction counter, branch class
package bpu_pkg;

	// ----------------------------------------
	// Addresses
	// ----------------------------------------

	// Full byte address
	typedef logic [31:0] addr_t;

	// Word address, a PC without its two low bits
	typedef logic [29:0] waddr_t;

	// ----------------------------------------
	// Direction counter
	// ----------------------------------------

	// 2-bit saturating counter, high bit gives the direction
	typedef logic [1:0] ctr_t;

	// Saturation limits
	localparam ctr_t CTR_STRONG_NT = 2'd0;
	localparam ctr_t CTR_STRONG_T  = 2'd3;

	// Reset value, weakly not taken
	localparam ctr_t CTR_WEAK_NT   = 2'd1;

	// ----------------------------------------
	// Branch class kept in the BTB
	// ----------------------------------------

	// Return picks the RAS top, PC-relative consults the counter
	typedef enum logic [1:0] {
		BR_PC_RELATIVE = 2'd0,
		BR_ABSOLUTE    = 2'd1,
		BR_CALL        = 2'd2,
		BR_RETURN      = 2'd3
	} br_class_e;

endpackage : bpu_pkg

// File: common/bpu_params.svh
// Table depths and index widths of the branch prediction unit
`ifndef BPU_PARAMS_SVH
`define BPU_PARAMS_SVH

// ----------------------------------------
// Branch target buffer
// ----------------------------------------

// Direct mapped, indexed by the low word-address bits
`define BTB_DEPTH 64
`define BTB_IDX_W 6

// Tag is the rest of the 30-bit word address
`define BTB_TAG_W (30 - `BTB_IDX_W)

// ----------------------------------------
// Direction counters
// ----------------------------------------

`define BHT_DEPTH 256
`define BHT_IDX_W 8

// ----------------------------------------
// Return address stack
// ----------------------------------------

`define RAS_DEPTH 8
`define RAS_PTR_W 3

`endif
